//--- include/sys16b_params.svh
// System 16B bus glue constants
`ifndef SYS16B_PARAMS_SVH
`define SYS16B_PARAMS_SVH

// Region indices into the active vector
// Regions 0 to 2 hold the program ROM
`define REG_RAM   3  // 68000 work RAM
`define REG_ORAM  4  // Object RAM
`define REG_VRAM  5  // Text/tile RAM with char RAM at A[16]
`define REG_PAL   6  // Color RAM
`define REG_IO    7  // I/O area

// Game ids that alter cabinet behavior
`define GAME_SDI      8'h01
`define GAME_PASSSHT  8'h02
`define GAME_BULLET   8'h11
`define GAME_PASSSHT2 8'h13
`define GAME_PASSSHT3 8'h18

// Decoded request buffer
`define FIFO_DEPTH 4

// ROM word address width, A[18:1]
`define ROM_AW 18

`endif

//--- logic/sys16b_pkg.sv
// System 16B bus glue types
`include "sys16b_params.svh"

package sys16b_pkg;

    // One target per bus cycle
    typedef enum logic [3:0] {
        tgt_rom,
        tgt_char_ram,
        tgt_vram,
        tgt_work_ram,
        tgt_obj_ram,
        tgt_pal_ram,
        tgt_io,
        tgt_tbank,
        tgt_unmapped
    } bus_target_e;

    // CPU bus cycle as seen by the glue logic
    typedef struct packed {
        logic [23:1] addr;
        logic [7:0]  active;   // One-hot region
        logic        rnw;
        logic [1:0]  dsn;      // Active low UDS/LDS
        logic [15:0] wdata;
    } bus_req_t;

    // Memory targets carry an address and I/O reads carry data
    typedef union packed {
        logic [`ROM_AW-1:0] mem;
        struct packed {
            logic [1:0]  pad;
            logic [15:0] rdata;
        } data;
    } payload_u;

    typedef struct packed {
        bus_target_e target;
        logic        rnw;
        logic [1:0]  dsn;
        logic [1:0]  io_sel;   // A[13:12]
        logic [1:0]  port_sel; // A[2:1]
        logic [15:0] wdata;
        payload_u    map;
    } dec_req_t;

    typedef struct packed {
        bus_target_e target;
        logic        rnw;
        payload_u    payload;
    } bus_rsp_t;

    typedef struct packed {
        logic [7:0] joystick1;
        logic [7:0] joystick2;
        logic [7:0] joystick3;
        logic [3:0] start_button;
        logic [3:0] coin_input;
        logic       service;
        logic       dip_test;
        logic [7:0] dipsw_a;
        logic [7:0] dipsw_b;
    } cab_in_t;

endpackage

//--- logic/bus_decoder.sv
// Region decoder and ROM bank mapper
`timescale 1ns/1ps
`include "sys16b_params.svh"

module bus_decoder
    import sys16b_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] game_id,
    input  bus_req_t   req,
    input  logic       req_valid,
    output logic       req_ready,
    output dec_req_t   dec,
    output logic       dec_valid,
    input  logic       dec_ready
);

    logic [1:0]         act_enc;
    logic [`ROM_AW-1:0] rom_addr;
    bus_target_e        target;
    dec_req_t           dec_next;
    logic               accept;

    // Output stage can take a new cycle when empty or draining
    assign req_ready = !dec_valid || dec_ready;
    assign accept    = req_valid && req_ready;

    // Which of the three ROM regions is selected
    always_comb begin
        case (req.active[2:0])
            3'b010:  act_enc = 2'd1;
            3'b100:  act_enc = 2'd2;
            default: act_enc = 2'd0;
        endcase
    end

    // Bank mapping per PCB family
    always_comb begin
        casez (game_id[7:3])
            5'b001??: begin // 5797
                rom_addr = req.addr[18:1];
            end
            5'b00010: begin // 5358
                if (game_id == 8'h10 || game_id == 8'h1a) begin
                    rom_addr = {act_enc, req.addr[16:1]}; // Large ROM board
                end else begin
                    rom_addr = {1'b0, act_enc, req.addr[15:1]};
                end
            end
            5'b00001: begin // Korean bootleg
                rom_addr = {1'b0, req.addr[17:1]};
            end
            default: begin // 5521 and 5704
                rom_addr = {act_enc[0], req.addr[17:1]};
            end
        endcase
    end

    always_comb begin
        if (|req.active[2:0]) begin
            if (req.rnw) begin
                target = tgt_rom;
            end else if (req.active[2]) begin
                target = tgt_tbank; // Tile bank latch sits on ROM region 2
            end else begin
                target = tgt_unmapped;
            end
        end else if (req.active[`REG_RAM]) begin
            target = tgt_work_ram;
        end else if (req.active[`REG_ORAM]) begin
            target = tgt_obj_ram;
        end else if (req.active[`REG_VRAM]) begin
            target = req.addr[16] ? tgt_char_ram : tgt_vram;
        end else if (req.active[`REG_PAL]) begin
            target = tgt_pal_ram;
        end else if (req.active[`REG_IO]) begin
            target = tgt_io;
        end else begin
            target = tgt_unmapped;
        end
    end

    always_comb begin
        dec_next.target   = target;
        dec_next.rnw      = req.rnw;
        dec_next.dsn      = req.dsn;
        dec_next.io_sel   = req.addr[13:12];
        dec_next.port_sel = req.addr[2:1];
        dec_next.wdata    = req.wdata;
        dec_next.map.mem  = '0;
        case (target)
            tgt_rom: begin
                dec_next.map.mem = rom_addr;
            end
            tgt_char_ram, tgt_vram, tgt_work_ram, tgt_obj_ram, tgt_pal_ram: begin
                dec_next.map.mem = {1'b0, req.addr[17:1]};
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (accept) begin
            dec_valid <= 1'b1;
        end else if (dec_ready) begin
            dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec <= dec_next;
        end
    end

endmodule

//--- logic/req_fifo.sv
// Decoded request buffer
`timescale 1ns/1ps
`include "sys16b_params.svh"

module req_fifo
    import sys16b_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  dec_req_t din,
    input  logic     din_valid,
    output logic     din_ready,
    output dec_req_t dout,
    output logic     dout_valid,
    input  logic     dout_ready
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);

    dec_req_t         mem [`FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             wr_en;
    logic             rd_en;

    assign din_ready  = count != (PTR_W+1)'(`FIFO_DEPTH);
    assign dout_valid = count != '0;
    assign dout       = mem[rd_ptr]; // Head entry
    assign wr_en      = din_valid && din_ready;
    assign rd_en      = dout_valid && dout_ready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- logic/io_port.sv
// I/O area and response stage
`timescale 1ns/1ps
`include "sys16b_params.svh"

module io_port
    import sys16b_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] game_id,
    input  cab_in_t    cab,
    input  dec_req_t   req,
    input  logic       req_valid,
    output logic       req_ready,
    output bus_rsp_t   rsp,
    output logic       rsp_valid,
    input  logic       rsp_ready,
    output logic       flip,
    output logic       video_en,
    output logic [5:0] tile_bank
);

    logic       xfer;
    logic       game_bullet;
    logic       game_passsht;
    logic [7:0] sort1;
    logic [7:0] sort2;
    logic [7:0] sort3;
    logic [7:0] sys_byte;
    logic [7:0] cab_byte;
    payload_u   rsp_payload;

    // Joystick bit order as seen by the CPU
    function automatic logic [7:0] sort_joy(input logic [7:0] joy);
        return {joy[1:0], joy[3:2], joy[7], joy[5:4], joy[6]};
    endfunction

    // Bullet wiring swaps the nibbles
    function automatic logic [7:0] nib_swap(input logic [7:0] val);
        return {val[3:0], val[7:4]};
    endfunction

    assign req_ready = !rsp_valid || rsp_ready;
    assign xfer      = req_valid && req_ready;

    assign game_bullet  = game_id == `GAME_BULLET;
    assign game_passsht = game_id == `GAME_PASSSHT || game_id == `GAME_PASSSHT2 ||
                          game_id == `GAME_PASSSHT3;

    assign sort1 = sort_joy(cab.joystick1);
    assign sort2 = sort_joy(cab.joystick2);
    assign sort3 = sort_joy(cab.joystick3);

    always_comb begin
        sys_byte = {2'b11, cab.start_button[1:0], cab.service, cab.dip_test,
                    cab.coin_input[1:0]};
        if (game_bullet) begin
            sys_byte[7:6] = {cab.coin_input[2], cab.start_button[2]}; // Third player
        end else if (game_passsht) begin
            sys_byte[7:6] = cab.start_button[3:2];
        end
    end

    // Cabinet read byte with block 3 custom inputs reading all ones
    always_comb begin
        cab_byte = 8'hff;
        case (req.io_sel)
            2'd1: begin
                case (req.port_sel)
                    2'd0: cab_byte = sys_byte;
                    2'd1: cab_byte = game_bullet ? nib_swap(sort1) : sort1;
                    2'd2: cab_byte = game_bullet ? nib_swap(sort3) : 8'hff;
                    2'd3: cab_byte = game_bullet ? nib_swap(sort2) : sort2;
                endcase
            end
            2'd2: cab_byte = req.port_sel[0] ? cab.dipsw_a : cab.dipsw_b;
            default: begin
            end
        endcase
    end

    always_comb begin
        rsp_payload = '0;
        case (req.target)
            tgt_io: begin
                if (req.rnw) begin
                    rsp_payload.data.rdata = {8'hff, cab_byte}; // Upper byte floats high
                end
            end
            tgt_tbank, tgt_unmapped: begin
            end
            default: rsp_payload = req.map; // Mapped word address
        endcase
    end

    // Video control and tile bank latches
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flip      <= 1'b0;
            video_en  <= 1'b1;
            tile_bank <= '0;
        end else if (xfer && !req.rnw && !req.dsn[0]) begin
            if (req.target == tgt_io && req.io_sel == 2'd0) begin
                flip     <= req.wdata[6];
                video_en <= req.wdata[5];
            end
            if (req.target == tgt_tbank) begin
                if (req.port_sel[0]) begin
                    tile_bank[5:3] <= req.wdata[2:0];
                end else begin
                    tile_bank[2:0] <= req.wdata[2:0];
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else if (xfer) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            rsp.target  <= req.target;
            rsp.rnw     <= req.rnw;
            rsp.payload <= rsp_payload;
        end
    end

endmodule

//--- logic/sys16b_io_top.sv
// System 16B bus glue top level
`timescale 1ns/1ps

module sys16b_io_top
    import sys16b_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] game_id,
    input  cab_in_t    cab,
    input  bus_req_t   req,
    input  logic       req_valid,
    output logic       req_ready,
    output bus_rsp_t   rsp,
    output logic       rsp_valid,
    input  logic       rsp_ready,
    output logic       flip,
    output logic       video_en,
    output logic [5:0] tile_bank
);

    dec_req_t dec;
    logic     dec_valid;
    logic     dec_ready;
    dec_req_t fifo_out;
    logic     fifo_valid;
    logic     fifo_ready;

    bus_decoder bus_decoder_inst (
        .clk       (clk),
        .rst       (rst),
        .game_id   (game_id),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .dec       (dec),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready)
    );

    // Holds decoded cycles while the response side stalls
    req_fifo req_fifo_inst (
        .clk        (clk),
        .rst        (rst),
        .din        (dec),
        .din_valid  (dec_valid),
        .din_ready  (dec_ready),
        .dout       (fifo_out),
        .dout_valid (fifo_valid),
        .dout_ready (fifo_ready)
    );

    io_port io_port_inst (
        .clk       (clk),
        .rst       (rst),
        .game_id   (game_id),
        .cab       (cab),
        .req       (fifo_out),
        .req_valid (fifo_valid),
        .req_ready (fifo_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .flip      (flip),
        .video_en  (video_en),
        .tile_bank (tile_bank)
    );

endmodule

//--- dv/tb_clock.sv
// Clock and reset generator
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0; // Released away from the active edge
    end

    always #5 clk = ~clk; // 10 ns period

endmodule

//--- dv/sys16b_io_assertions.sv
// Handshake and reset assertions
`timescale 1ns/1ps

module sys16b_io_assertions #(
    parameter int DW         = 8,
    parameter bit CHECK_CTRL = 1'b0
) (
    input logic          clk,
    input logic          rst,
    input logic          in_valid,
    input logic          out_valid,
    input logic          out_ready,
    input logic [DW-1:0] out_data,
    input logic [7:0]    ctrl
);

    // Flip off, video on, tile bank zero
    localparam logic [7:0] CTRL_RST = 8'h40;

    hold_valid: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid)
        else $error("Output valid dropped before ready");

    // Stalled output must not change
    hold_data: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> $stable(out_data))
        else $error("Output payload changed while stalled");

    reset_state: assert property (@(posedge clk)
        rst && $past(rst) |-> !out_valid && (!CHECK_CTRL || ctrl == CTRL_RST))
        else $error("Outputs not at reset values during reset");

    known_valid: assert property (@(posedge clk) disable iff (rst)
        !$isunknown({in_valid, out_valid}))
        else $error("Valid signal is unknown");

endmodule

//--- dv/sys16b_io_tb.sv
// System 16B bus glue testbench
`timescale 1ns/1ps

module sys16b_io_tb
    import sys16b_pkg::*;
();

    // One stimulus line with its expected response
    typedef struct packed {
        logic       is_cfg;
        logic [7:0] game;
        cab_in_t    cab;
        bus_req_t   req;
        bus_rsp_t   exp_rsp;
        logic       chk_ctrl;
        logic       exp_flip;
        logic       exp_video_en;
        logic [5:0] exp_tile_bank;
    } stim_t;

    logic       clk;
    logic       rst;
    logic [7:0] game_id;
    cab_in_t    cab;
    bus_req_t   req;
    logic       req_valid;
    logic       req_ready;
    bus_rsp_t   rsp;
    logic       rsp_valid;
    logic       rsp_ready;
    logic       flip;
    logic       video_en;
    logic [5:0] tile_bank;

    stim_t stim_q[$];
    stim_t exp_q[$];  // Requests still awaiting their response
    int    cycle_count = 0;
    int    cycle_limit = 0;

    tb_clock tb_clock_inst (.clk(clk), .rst(rst));

    sys16b_io_top sys16b_io_top_inst (
        .clk       (clk),
        .rst       (rst),
        .game_id   (game_id),
        .cab       (cab),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .flip      (flip),
        .video_en  (video_en),
        .tile_bank (tile_bank)
    );

    bind bus_decoder sys16b_io_assertions #(
        .DW($bits(sys16b_pkg::dec_req_t)), .CHECK_CTRL(1'b0)
    ) dec_sva (
        .clk(clk), .rst(rst), .in_valid(req_valid), .out_valid(dec_valid),
        .out_ready(dec_ready), .out_data(dec), .ctrl(8'h00)
    );

    bind io_port sys16b_io_assertions #(
        .DW($bits(sys16b_pkg::bus_rsp_t)), .CHECK_CTRL(1'b1)
    ) rsp_sva (
        .clk(clk), .rst(rst), .in_valid(req_valid), .out_valid(rsp_valid),
        .out_ready(rsp_ready), .out_data(rsp), .ctrl({flip, video_en, tile_bank})
    );

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "run aborted at %0t", $time);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL time=%0t %s got=%0h expected=%0h", $time, name, got, exp);
            abort_run();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic load_stim();
        int          fd;
        int          status;
        string       line;
        logic [31:0] f [11];
        stim_t       s;
        fd = $fopen("dv/sys16b_stim.txt", "r");
        if (fd == 0) begin
            $display("Stimulus file dv/sys16b_stim.txt could not be opened");
            abort_run();
        end else begin
            while (!$feof(fd)) begin
                line = "";
                status = $fgets(line, fd);
                s = '0;
                if (line.len() < 2 || line[0] == "#") begin
                    status = -1; // Comment or blank line
                end else if (line[0] == "C") begin
                    status = $sscanf(line, "C %h %h %h %h %h %h %h %h %h %h", f[0], f[1],
                                     f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
                    s.is_cfg           = 1'b1;
                    s.game             = f[0][7:0];
                    s.cab.joystick1    = f[1][7:0];
                    s.cab.joystick2    = f[2][7:0];
                    s.cab.joystick3    = f[3][7:0];
                    s.cab.start_button = f[4][3:0];
                    s.cab.coin_input   = f[5][3:0];
                    s.cab.service      = f[6][0];
                    s.cab.dip_test     = f[7][0];
                    s.cab.dipsw_a      = f[8][7:0];
                    s.cab.dipsw_b      = f[9][7:0];
                    status = (status == 10) ? 1 : 0;
                end else begin
                    status = $sscanf(line, "R %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1],
                                     f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
                    s.req.addr            = f[0][23:1]; // Byte address in the file
                    s.req.active          = f[1][7:0];
                    s.req.rnw             = f[2][0];
                    s.req.dsn             = f[3][1:0];
                    s.req.wdata           = f[4][15:0];
                    s.exp_rsp.target      = bus_target_e'(f[5][3:0]);
                    s.exp_rsp.rnw         = f[2][0];
                    s.exp_rsp.payload.mem = f[6][17:0];
                    s.chk_ctrl            = f[7][0];
                    s.exp_flip            = f[8][0];
                    s.exp_video_en        = f[9][0];
                    s.exp_tile_bank       = f[10][5:0];
                    status = (status == 11) ? 1 : 0;
                end
                if (status == 0) begin
                    $display("Malformed stimulus line: %s", line);
                    abort_run();
                end else if (status == 1) begin
                    stim_q.push_back(s);
                end
            end
            $fclose(fd);
        end
    endtask

    // Request driver
    initial begin
        stim_t s;
        game_id   = '0;
        cab       = '0;
        req       = '0;
        req_valid = 1'b0;
        load_stim();
        cycle_limit = stim_q.size() * 40;
        wait (rst);
        wait (!rst);
        @(negedge clk);
        foreach (stim_q[i]) begin
            s = stim_q[i];
            if (s.is_cfg) begin
                req_valid = 1'b0;
                while (exp_q.size() != 0) begin
                    @(negedge clk); // Drain before the game changes
                end
                game_id = s.game;
                cab     = s.cab;
            end else begin
                req       = s.req;
                req_valid = 1'b1;
                exp_q.push_back(s);
                while (!req_ready) begin
                    @(negedge clk);
                end
                @(negedge clk);
            end
        end
        req_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        $display("Testbench passed");
        $finish;
    end

    // Response checker with random back-pressure
    initial begin
        stim_t       want;
        logic [31:0] rng_state;
        rng_state = 32'h61e6;
        rsp_ready = 1'b0;
        wait (rst);
        wait (!rst);
        forever begin
            @(negedge clk);
            rng_state = xorshift32(rng_state);
            rsp_ready = rng_state[1:0] != 2'b00; // Ready about 3 cycles in 4
            // Response taken on the coming rising edge
            if (rsp_valid && rsp_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Response seen with no request outstanding");
                    abort_run();
                end else begin
                    want = exp_q.pop_front();
                    check_value("rsp.target", 32'(rsp.target), 32'(want.exp_rsp.target));
                    check_value("rsp.rnw", 32'(rsp.rnw), 32'(want.exp_rsp.rnw));
                    check_value("rsp.payload", 32'(rsp.payload.mem),
                                32'(want.exp_rsp.payload.mem));
                    if (want.chk_ctrl) begin
                        check_value("flip", 32'(flip), 32'(want.exp_flip));
                        check_value("video_en", 32'(video_en), 32'(want.exp_video_en));
                        check_value("tile_bank", 32'(tile_bank), 32'(want.exp_tile_bank));
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles with responses still missing", cycle_count);
            abort_run();
        end
    end

endmodule

//--- dv/sys16b_stim.txt
# C game_id joy1 joy2 joy3 start coin service dip_test dipsw_a dipsw_b
# R byte_addr active rnw dsn wdata target(0 rom..8 unmapped) payload chk flip video_en tile_bank
C 00 e1 3c 96 a 5 1 0 3f c7
R c41000 80 1 0 0000 6 0ffe9 1 0 1 00
R c41002 80 1 0 0000 6 0ff4d 0 0 0 00
R c41004 80 1 0 0000 6 0ffff 0 0 0 00
R c41006 80 1 0 0000 6 0ff36 0 0 0 00
R c42000 80 1 0 0000 6 0ffc7 0 0 0 00
R c42002 80 1 0 0000 6 0ff3f 0 0 0 00
R c43004 80 1 0 0000 6 0ffff 0 0 0 00
C 11 e1 3c 96 a 5 1 0 3f c7
R c41000 80 1 0 0000 6 0ffa9 0 0 0 00
R c41002 80 1 0 0000 6 0ffd4 0 0 0 00
R c41004 80 1 0 0000 6 0ffa9 0 0 0 00
R c41006 80 1 0 0000 6 0ff63 0 0 0 00
C 02 e1 3c 96 6 5 1 0 3f c7
R c41000 80 1 0 0000 6 0ff69 0 0 0 00
R c41002 80 1 0 0000 6 0ff4d 0 0 0 00
C 20 e1 3c 96 a 5 1 0 3f c7
R 07a5b6 01 1 0 0000 0 3d2db 0 0 0 00
C 10 e1 3c 96 a 5 1 0 3f c7
R 07a5b6 04 1 0 0000 0 2d2db 0 0 0 00
R 07a5b6 02 1 0 0000 0 1d2db 0 0 0 00
C 12 e1 3c 96 a 5 1 0 3f c7
R 07a5b6 02 1 0 0000 0 0d2db 0 0 0 00
R 07a5b6 04 1 0 0000 0 152db 0 0 0 00
C 08 e1 3c 96 a 5 1 0 3f c7
R 07a5b6 02 1 0 0000 0 1d2db 0 0 0 00
C 00 e1 3c 96 a 5 1 0 3f c7
R 07a5b6 01 1 0 0000 0 1d2db 0 0 0 00
R 07a5b6 02 1 0 0000 0 3d2db 0 0 0 00
R 07a5b6 04 1 0 0000 0 1d2db 0 0 0 00
R 07a5b6 08 1 0 0000 3 1d2db 0 0 0 00
R 07a5b6 10 1 0 0000 4 1d2db 0 0 0 00
R 07a5b6 20 1 0 0000 1 1d2db 0 0 0 00
R 06a5b6 20 1 0 0000 2 152db 0 0 0 00
R 07a5b6 40 1 0 0000 5 1d2db 0 0 0 00
R 07a5b6 01 0 0 1234 8 00000 0 0 0 00
R 07a5b6 00 1 0 0000 8 00000 0 0 0 00
# Video control and tile bank writes
R c40000 80 0 0 0060 6 00000 1 1 1 00
R c40000 80 0 0 0040 6 00000 1 1 0 00
R c40000 80 0 1 0020 6 00000 1 1 0 00
R 000002 04 0 0 0005 7 00000 1 1 0 28
R 000000 04 0 0 0003 7 00000 1 1 0 2b
R 000000 04 0 1 0006 7 00000 1 1 0 2b
R c40000 80 0 0 0020 6 00000 1 0 1 2b

//--- compile.f
+incdir+include
logic/sys16b_pkg.sv
logic/bus_decoder.sv
logic/req_fifo.sv
logic/io_port.sv
logic/sys16b_io_top.sv
dv/tb_clock.sv
dv/sys16b_io_assertions.sv
dv/sys16b_io_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module sys16b_io_tb \
    -f compile.f -o sys16b_io_sim \
    && ./obj_dir/sys16b_io_sim \
    || { echo "Simulation did not complete successfully"; exit 1; }
